// File: logic/rv_core_pkg.sv
package rv_core_pkg;

  // Datapath and bus widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SEL_W      = 4;

  // Major opcodes kept by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ALU funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Store funct3, low two bits give the access size
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // SUB and SRA/SRAI select
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  // ALU operations
  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

  // One instruction word, four format views
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s;
    struct packed {
      logic [19:0]           imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } u;
  } instr_u;

endpackage

// File: logic/register_file.sv
module register_file import rv_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  // x1 to x31, no storage for x0
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int k = 1; k < NUM_REGS; k++) begin
        regs_q[k] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: logic/if_stage.sv
module if_stage import rv_core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic [XLEN-1:0] ibus_dat_i,
  input  logic            ibus_ack_i,
  input  logic            id_ready_i,
  output logic            ibus_cyc_o,
  output logic            ibus_stb_o,
  output logic [XLEN-1:0] ibus_adr_o,
  output logic            if_valid_o,
  output instr_u          if_instr_o
);

  // First cycle out of reset, PC still to be loaded
  logic            boot_q;
  // Wishbone read in flight
  logic            req_q;
  // Address of the current or next fetch
  logic [XLEN-1:0] pc_q;
  // Hold register toward decode
  logic            hold_valid_q;
  instr_u          hold_instr_q;
  logic            fetch_done;
  logic            hold_free;

  assign fetch_done = req_q & ibus_ack_i;
  // Empty now, or decode takes the word this cycle
  assign hold_free  = ~hold_valid_q | id_ready_i;

  //////////////////////////////
  // Fetch master
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_q <= 1'b1;
      req_q  <= 1'b0;
      pc_q   <= '0;
    end else if (boot_q) begin
      // Boot fetch goes out right after reset
      boot_q <= 1'b0;
      req_q  <= 1'b1;
      pc_q   <= boot_addr_i;
    end else if (req_q) begin
      // Drop the strobe after ack, step PC
      if (ibus_ack_i) begin
        req_q <= 1'b0;
        pc_q  <= pc_q + XLEN'(4);
      end
    end else if (hold_free) begin
      // Room for the next word by the time it returns
      req_q <= 1'b1;
    end
  end

  // cyc and stb move together, one read at a time
  assign ibus_cyc_o = req_q;
  assign ibus_stb_o = req_q;
  assign ibus_adr_o = pc_q;

  //////////////////////////////
  // Hold register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
    end else if (fetch_done) begin
      hold_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  // Word captured on ack
  always_ff @(posedge clk_i) begin
    if (fetch_done) begin
      hold_instr_q <= ibus_dat_i;
    end
  end

  assign if_valid_o = hold_valid_q;
  assign if_instr_o = hold_instr_q;

endmodule

// File: logic/id_stage.sv
module id_stage import rv_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  if_valid_i,
  input  instr_u                if_instr_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,
  input  logic                  ex_ready_i,
  output logic                  id_ready_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic                  id_valid_o,
  output logic [ALU_OP_W-1:0]   id_alu_op_o,
  output logic [XLEN-1:0]       id_op_a_o,
  output logic [XLEN-1:0]       id_op_b_o,
  output logic [XLEN-1:0]       id_store_data_o,
  output logic [REG_ADDR_W-1:0] id_rd_o,
  output logic                  id_rd_we_o,
  output logic                  id_store_o,
  output logic [1:0]            id_store_size_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                alt;
  logic                is_op;
  logic                is_op_imm;
  logic                is_lui;
  logic                is_store;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_s;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     rs1_val;
  logic [XLEN-1:0]     rs2_val;
  logic [XLEN-1:0]     op_b;
  logic [ALU_OP_W-1:0] alu_op;
  logic                accept;
  logic                valid_q;

  // Value from EX wins over the register file, never for x0
  function automatic logic [XLEN-1:0] bypass(input logic [REG_ADDR_W-1:0] idx,
                                             input logic [XLEN-1:0]       rf_val);
    if (rf_we_i && (rf_waddr_i == idx) && (idx != '0)) begin
      return rf_wdata_i;
    end
    return rf_val;
  endfunction

  //////////////////////////////
  // Decode
  //////////////////////////////

  // Opcode and funct fields sit alike in all formats
  assign opcode = if_instr_i.r.opcode;
  assign funct3 = if_instr_i.r.funct3;
  assign alt    = (if_instr_i.r.funct7 == F7_ALT);

  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);
  assign is_lui    = (opcode == OPC_LUI);
  // SB, SH, SW only
  assign is_store  = (opcode == OPC_STORE) &&
                     ((funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW));

  // Immediates, sign extended from bit 31
  assign imm_i = {{(XLEN-12){if_instr_i.i.imm[11]}}, if_instr_i.i.imm};
  assign imm_s = {{(XLEN-12){if_instr_i.s.imm_hi[6]}}, if_instr_i.s.imm_hi,
                  if_instr_i.s.imm_lo};
  assign imm_u = {if_instr_i.u.imm, 12'b0};

  always_comb begin
    // Stores and unknown opcodes add
    alu_op = ALU_ADD;
    if (is_lui) begin
      alu_op = ALU_PASS_B;
    end else if (is_op || is_op_imm) begin
      case (funct3)
        // No SUBI, funct7 only counts for OP
        F3_ADD_SUB: alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
        F3_SLL:     alu_op = ALU_SLL;
        F3_SLT:     alu_op = ALU_SLT;
        F3_SLTU:    alu_op = ALU_SLTU;
        F3_XOR:     alu_op = ALU_XOR;
        F3_SR:      alu_op = alt ? ALU_SRA : ALU_SRL;
        F3_OR:      alu_op = ALU_OR;
        F3_AND:     alu_op = ALU_AND;
      endcase
    end
  end

  //////////////////////////////
  // Operands
  //////////////////////////////

  assign rf_raddr_a_o = if_instr_i.r.rs1;
  assign rf_raddr_b_o = if_instr_i.r.rs2;

  assign rs1_val = bypass(if_instr_i.r.rs1, rf_rdata_a_i);
  assign rs2_val = bypass(if_instr_i.r.rs2, rf_rdata_b_i);

  // B is rs2 or one of the immediates
  always_comb begin
    if (is_op) begin
      op_b = rs2_val;
    end else if (is_store) begin
      op_b = imm_s;
    end else if (is_lui) begin
      op_b = imm_u;
    end else begin
      op_b = imm_i;
    end
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  // Take a new one when empty or EX drains this cycle
  assign id_ready_o = ~valid_q | ex_ready_i;
  assign accept     = if_valid_i & id_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (id_ready_o) begin
      valid_q <= if_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_alu_op_o     <= alu_op;
      id_op_a_o       <= rs1_val;
      id_op_b_o       <= op_b;
      id_store_data_o <= rs2_val;
      id_rd_o         <= if_instr_i.r.rd;
      // Unknown opcodes become no-ops here
      id_rd_we_o      <= is_op | is_op_imm | is_lui;
      id_store_o      <= is_store;
      id_store_size_o <= funct3[1:0];
    end
  end

  assign id_valid_o = valid_q;

endmodule

// File: logic/ex_stage.sv
module ex_stage import rv_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  id_valid_i,
  input  logic [ALU_OP_W-1:0]   id_alu_op_i,
  input  logic [XLEN-1:0]       id_op_a_i,
  input  logic [XLEN-1:0]       id_op_b_i,
  input  logic [XLEN-1:0]       id_store_data_i,
  input  logic [REG_ADDR_W-1:0] id_rd_i,
  input  logic                  id_rd_we_i,
  input  logic                  id_store_i,
  input  logic [1:0]            id_store_size_i,
  input  logic                  dbus_ack_i,
  output logic                  ex_ready_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  dbus_cyc_o,
  output logic                  dbus_stb_o,
  output logic [XLEN-1:0]       dbus_adr_o,
  output logic [SEL_W-1:0]      dbus_sel_o,
  output logic [XLEN-1:0]       dbus_dat_o
);

  logic [XLEN-1:0]  alu_res;
  logic [4:0]       shamt;
  logic             store_ex;
  logic [SEL_W-1:0] sel;
  logic [XLEN-1:0]  lane_data;
  logic             req_q;
  logic [XLEN-1:0]  adr_q;
  logic [SEL_W-1:0] sel_q;
  logic [XLEN-1:0]  dat_q;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // Shift amount from the low five bits
  assign shamt = id_op_b_i[4:0];

  always_comb begin
    case (id_alu_op_i)
      ALU_ADD:    alu_res = id_op_a_i + id_op_b_i;
      ALU_SUB:    alu_res = id_op_a_i - id_op_b_i;
      ALU_AND:    alu_res = id_op_a_i & id_op_b_i;
      ALU_OR:     alu_res = id_op_a_i | id_op_b_i;
      ALU_XOR:    alu_res = id_op_a_i ^ id_op_b_i;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(id_op_a_i) < $signed(id_op_b_i)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, id_op_a_i < id_op_b_i};
      ALU_SLL:    alu_res = id_op_a_i << shamt;
      ALU_SRL:    alu_res = id_op_a_i >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(id_op_a_i) >>> shamt);
      ALU_PASS_B: alu_res = id_op_b_i;
      default:    alu_res = '0;
    endcase
  end

  // Single-cycle write-back, visible to decode as bypass
  assign rf_we_o    = id_valid_i & id_rd_we_i;
  assign rf_waddr_o = id_rd_i;
  assign rf_wdata_o = alu_res;

  //////////////////////////////
  // Store master
  //////////////////////////////

  assign store_ex = id_valid_i & id_store_i;

  // Lane mask and replicated data, address is the ALU sum
  always_comb begin
    if (id_store_size_i == F3_SB[1:0]) begin
      sel       = SEL_W'(1) << alu_res[1:0];
      lane_data = {4{id_store_data_i[7:0]}};
    end else if (id_store_size_i == F3_SH[1:0]) begin
      sel       = alu_res[1] ? 4'b1100 : 4'b0011;
      lane_data = {2{id_store_data_i[15:0]}};
    end else begin
      sel       = 4'b1111;
      lane_data = id_store_data_i;
    end
  end

  // Stall the pipe until the store is acked
  assign ex_ready_o = ~store_ex | (req_q & dbus_ack_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (req_q) begin
      if (dbus_ack_i) begin
        req_q <= 1'b0;
      end
    end else if (store_ex) begin
      req_q <= 1'b1;
    end
  end

  // Request payload, frozen while the strobe is up
  always_ff @(posedge clk_i) begin
    if (!req_q && store_ex) begin
      adr_q <= alu_res;
      sel_q <= sel;
      dat_q <= lane_data;
    end
  end

  assign dbus_cyc_o = req_q;
  assign dbus_stb_o = req_q;
  assign dbus_adr_o = adr_q;
  assign dbus_sel_o = sel_q;
  assign dbus_dat_o = dat_q;

endmodule

// File: logic/rv_core_top.sv
module rv_core_top import rv_core_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [XLEN-1:0]  boot_addr_i,
  // Instruction bus
  output logic             ibus_cyc_o,
  output logic             ibus_stb_o,
  output logic [XLEN-1:0]  ibus_adr_o,
  input  logic [XLEN-1:0]  ibus_dat_i,
  input  logic             ibus_ack_i,
  // Data bus, write only
  output logic             dbus_cyc_o,
  output logic             dbus_stb_o,
  output logic [XLEN-1:0]  dbus_adr_o,
  output logic [SEL_W-1:0] dbus_sel_o,
  output logic [XLEN-1:0]  dbus_dat_o,
  input  logic             dbus_ack_i
);

  // IF to ID
  logic                  if_valid;
  instr_u                if_instr;
  logic                  id_ready;
  // Register file read ports
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  // ID/EX fields
  logic                  id_valid;
  logic [ALU_OP_W-1:0]   id_alu_op;
  logic [XLEN-1:0]       id_op_a;
  logic [XLEN-1:0]       id_op_b;
  logic [XLEN-1:0]       id_store_data;
  logic [REG_ADDR_W-1:0] id_rd;
  logic                  id_rd_we;
  logic                  id_store;
  logic [1:0]            id_store_size;
  logic                  ex_ready;
  // Write-back, also the bypass source
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  //////////////////////////////
  // Fetch
  //////////////////////////////

  if_stage if_stage0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .boot_addr_i (boot_addr_i),
    .ibus_dat_i  (ibus_dat_i),
    .ibus_ack_i  (ibus_ack_i),
    .id_ready_i  (id_ready),
    .ibus_cyc_o  (ibus_cyc_o),
    .ibus_stb_o  (ibus_stb_o),
    .ibus_adr_o  (ibus_adr_o),
    .if_valid_o  (if_valid),
    .if_instr_o  (if_instr)
  );

  //////////////////////////////
  // Decode and operands
  //////////////////////////////

  id_stage id_stage0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .if_valid_i      (if_valid),
    .if_instr_i      (if_instr),
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .rf_we_i         (rf_we),
    .rf_waddr_i      (rf_waddr),
    .rf_wdata_i      (rf_wdata),
    .ex_ready_i      (ex_ready),
    .id_ready_o      (id_ready),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .id_valid_o      (id_valid),
    .id_alu_op_o     (id_alu_op),
    .id_op_a_o       (id_op_a),
    .id_op_b_o       (id_op_b),
    .id_store_data_o (id_store_data),
    .id_rd_o         (id_rd),
    .id_rd_we_o      (id_rd_we),
    .id_store_o      (id_store),
    .id_store_size_o (id_store_size)
  );

  //////////////////////////////
  // Execute and write-back
  //////////////////////////////

  ex_stage ex_stage0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .id_valid_i      (id_valid),
    .id_alu_op_i     (id_alu_op),
    .id_op_a_i       (id_op_a),
    .id_op_b_i       (id_op_b),
    .id_store_data_i (id_store_data),
    .id_rd_i         (id_rd),
    .id_rd_we_i      (id_rd_we),
    .id_store_i      (id_store),
    .id_store_size_i (id_store_size),
    .dbus_ack_i      (dbus_ack_i),
    .ex_ready_o      (ex_ready),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .dbus_cyc_o      (dbus_cyc_o),
    .dbus_stb_o      (dbus_stb_o),
    .dbus_adr_o      (dbus_adr_o),
    .dbus_sel_o      (dbus_sel_o),
    .dbus_dat_o      (dbus_dat_o)
  );

  register_file register_file0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

endmodule

// File: bench/rv_core_assert.sv
module rv_core_assert import rv_core_pkg::*; (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             ibus_cyc_i,
  input logic             ibus_stb_i,
  input logic [XLEN-1:0]  ibus_adr_i,
  input logic             ibus_ack_i,
  input logic             dbus_cyc_i,
  input logic             dbus_stb_i,
  input logic [XLEN-1:0]  dbus_adr_i,
  input logic [SEL_W-1:0] dbus_sel_i,
  input logic [XLEN-1:0]  dbus_dat_i,
  input logic             dbus_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // Instruction bus
  //////////////////////////////

  ibus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_stb_i |-> ibus_cyc_i)
    else $error("ibus stb high without cyc");

  // Request and address frozen until ack
  ibus_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ibus_stb_i && !ibus_ack_i) |=> (ibus_stb_i && $stable(ibus_adr_i)))
    else $error("ibus request dropped or address changed before ack");

  // One read at a time, idle cycle after each ack
  ibus_one_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_ack_i |=> !ibus_stb_i)
    else $error("ibus request still up after ack");

  //////////////////////////////
  // Data bus
  //////////////////////////////

  dbus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_stb_i |-> dbus_cyc_i)
    else $error("dbus stb high without cyc");

  dbus_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dbus_stb_i && !dbus_ack_i) |=> (dbus_stb_i && $stable(dbus_adr_i) &&
                                     $stable(dbus_sel_i) && $stable(dbus_dat_i)))
    else $error("dbus request dropped or payload changed before ack");

  dbus_one_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_ack_i |=> !dbus_stb_i)
    else $error("dbus request still up after ack");

endmodule

bind rv_core_top rv_core_assert rv_core_assert0 (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .ibus_cyc_i (ibus_cyc_o),
  .ibus_stb_i (ibus_stb_o),
  .ibus_adr_i (ibus_adr_o),
  .ibus_ack_i (ibus_ack_i),
  .dbus_cyc_i (dbus_cyc_o),
  .dbus_stb_i (dbus_stb_o),
  .dbus_adr_i (dbus_adr_o),
  .dbus_sel_i (dbus_sel_o),
  .dbus_dat_i (dbus_dat_o),
  .dbus_ack_i (dbus_ack_i)
);

// File: bench/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN       = 200;
  localparam int SEED           = 69829;
  // Two bus transfers of up to four cycles plus slack per instruction
  localparam int TIMEOUT_CYCLES = PROG_LEN * (2 * 4 + 4) + 100;
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h8000_0100;

  logic             clk_i;
  logic             rst_n_i;
  logic [XLEN-1:0]  boot_addr_i;
  logic             ibus_cyc_o;
  logic             ibus_stb_o;
  logic [XLEN-1:0]  ibus_adr_o;
  logic [XLEN-1:0]  ibus_dat_i;
  logic             ibus_ack_i;
  logic             dbus_cyc_o;
  logic             dbus_stb_o;
  logic [XLEN-1:0]  dbus_adr_o;
  logic [SEL_W-1:0] dbus_sel_o;
  logic [XLEN-1:0]  dbus_dat_o;
  logic             dbus_ack_i;

  // Program image and reference model state
  instr_u           prog [PROG_LEN];
  logic [XLEN-1:0]  model_regs [NUM_REGS];
  logic [XLEN-1:0]  exp_adr_q [$];
  logic [SEL_W-1:0] exp_sel_q [$];
  logic [XLEN-1:0]  exp_dat_q [$];
  logic [31:0]      rng_state;
  // Responder and monitor progress
  int               cycle_cnt;
  int               fetch_idx;
  int               dec_idx;
  int               ibus_wait;
  int               dbus_wait;
  logic             ibus_armed;
  logic             dbus_armed;

  rv_core_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .boot_addr_i (boot_addr_i),
    .ibus_cyc_o  (ibus_cyc_o),
    .ibus_stb_o  (ibus_stb_o),
    .ibus_adr_o  (ibus_adr_o),
    .ibus_dat_i  (ibus_dat_i),
    .ibus_ack_i  (ibus_ack_i),
    .dbus_cyc_o  (dbus_cyc_o),
    .dbus_stb_o  (dbus_stb_o),
    .dbus_adr_o  (dbus_adr_o),
    .dbus_sel_o  (dbus_sel_o),
    .dbus_dat_o  (dbus_dat_o),
    .dbus_ack_i  (dbus_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper bits only as the low LCG bits cycle short
  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 12) % n;
  endfunction

  // Only x0..x7 so dependencies come often
  function automatic logic [REG_ADDR_W-1:0] pick_reg();
    return REG_ADDR_W'(rand_below(8));
  endfunction

  function automatic instr_u make_instr();
    instr_u     w;
    int         kind;
    logic [2:0] f3;
    w    = NOP_INSTR;
    kind = rand_below(10);
    f3   = 3'(rand_below(8));
    if (kind < 3) begin
      w.r.opcode = OPC_OP;
      w.r.funct3 = f3;
      w.r.rd     = pick_reg();
      w.r.rs1    = pick_reg();
      w.r.rs2    = pick_reg();
      w.r.funct7 = 7'b0;
      // SUB and SRA half the time
      if (((f3 == F3_ADD_SUB) || (f3 == F3_SR)) && (rand_below(2) == 1)) begin
        w.r.funct7 = F7_ALT;
      end
    end else if (kind < 6) begin
      w.i.opcode = OPC_OP_IMM;
      w.i.funct3 = f3;
      w.i.rd     = pick_reg();
      w.i.rs1    = pick_reg();
      w.i.imm    = 12'(lcg_next() >> 20);
      // Shift immediates carry funct7 in the top bits
      if (f3 == F3_SLL) begin
        w.i.imm[11:5] = 7'b0;
      end else if (f3 == F3_SR) begin
        w.i.imm[11:5] = (rand_below(2) == 1) ? F7_ALT : 7'b0;
      end
    end else if (kind == 6) begin
      w.u.opcode = OPC_LUI;
      w.u.rd     = pick_reg();
      w.u.imm    = 20'(lcg_next() >> 12);
    end else begin
      w.s.opcode = OPC_STORE;
      w.s.funct3 = 3'(rand_below(3));
      w.s.rs1    = pick_reg();
      w.s.rs2    = pick_reg();
      w.s.imm_hi = 7'(lcg_next() >> 25);
      w.s.imm_lo = 5'(lcg_next() >> 27);
    end
    return w;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic model_exec(input instr_u w);
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  res;
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  data;
    logic [SEL_W-1:0] sel;
    logic [4:0]       sh;
    logic             alt;
    a   = model_regs[w.r.rs1];
    b   = model_regs[w.r.rs2];
    res = '0;
    if ((w.r.opcode == OPC_OP) || (w.r.opcode == OPC_OP_IMM)) begin
      if (w.r.opcode == OPC_OP_IMM) begin
        b = {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
      end
      alt = (w.r.funct7 == F7_ALT);
      sh  = b[4:0];
      case (w.r.funct3)
        F3_ADD_SUB: res = (alt && (w.r.opcode == OPC_OP)) ? a - b : a + b;
        F3_SLL:     res = a << sh;
        F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
        F3_XOR:     res = a ^ b;
        F3_SR:      res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
        F3_OR:      res = a | b;
        default:    res = a & b;
      endcase
      if (w.r.rd != '0) model_regs[w.r.rd] = res;
    end else if (w.u.opcode == OPC_LUI) begin
      if (w.u.rd != '0) model_regs[w.u.rd] = {w.u.imm, 12'b0};
    end else if (w.s.opcode == OPC_STORE) begin
      addr = a + {{(XLEN-12){w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
      case (w.s.funct3)
        F3_SB: begin
          sel  = 4'b0001 << addr[1:0];
          data = {4{b[7:0]}};
        end
        F3_SH: begin
          sel  = addr[1] ? 4'b1100 : 4'b0011;
          data = {2{b[15:0]}};
        end
        default: begin
          sel  = 4'b1111;
          data = b;
        end
      endcase
      exp_adr_q.push_back(addr);
      exp_sel_q.push_back(sel);
      exp_dat_q.push_back(data);
    end
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic fail_stop();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic check_fetch_adr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ibus_adr_o got %h expected %h", $time, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_store_adr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t dbus_adr_o got %h expected %h", $time, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_store_sel(input logic [SEL_W-1:0] got, input logic [SEL_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t dbus_sel_o got %b expected %b", $time, got, exp);
      fail_stop();
    end
  endtask

  // Only lanes enabled by sel count
  task automatic check_store_dat(input logic [XLEN-1:0]  got,
                                 input logic [XLEN-1:0]  exp,
                                 input logic [SEL_W-1:0] sel);
    logic [XLEN-1:0] mask;
    mask = '0;
    for (int k = 0; k < SEL_W; k++) begin
      mask[8*k +: 8] = {8{sel[k]}};
    end
    if ((got & mask) !== (exp & mask)) begin
      $display("[FAIL] %0t dbus_dat_o got %h expected %h", $time, got & mask, exp & mask);
      fail_stop();
    end
  endtask

  task automatic check_instr(input instr_u got, input instr_u exp);
    if (got !== exp) begin
      $display("[FAIL] %0t if_instr got %h expected %h", $time, got, exp);
      fail_stop();
    end
  endtask

  //////////////////////////////
  // Bus responders and monitor
  //////////////////////////////

  task automatic serve_ibus();
    if (ibus_ack_i) begin
      ibus_ack_i = 1'b0;
    end else if (ibus_stb_o) begin
      if (!ibus_armed) begin
        ibus_wait  = rand_below(4);
        ibus_armed = 1'b1;
      end
      if (ibus_wait == 0) begin
        check_fetch_adr(ibus_adr_o, boot_addr_i + (XLEN'(fetch_idx) << 2));
        // Past the program the core runs on no-ops
        ibus_dat_i = (fetch_idx < PROG_LEN) ? prog[fetch_idx] : NOP_INSTR;
        ibus_ack_i = 1'b1;
        ibus_armed = 1'b0;
        fetch_idx++;
      end else begin
        ibus_wait--;
      end
    end
  endtask

  task automatic serve_dbus();
    logic [SEL_W-1:0] exp_sel;
    if (dbus_ack_i) begin
      dbus_ack_i = 1'b0;
    end else if (dbus_stb_o) begin
      if (!dbus_armed) begin
        dbus_wait  = rand_below(4);
        dbus_armed = 1'b1;
      end
      if (dbus_wait != 0) begin
        dbus_wait--;
      end else if (exp_adr_q.size() == 0) begin
        $display("Store to %h issued but the program has no store left", dbus_adr_o);
        fail_stop();
      end else begin
        exp_sel = exp_sel_q.pop_front();
        check_store_adr(dbus_adr_o, exp_adr_q.pop_front());
        check_store_sel(dbus_sel_o, exp_sel);
        check_store_dat(dbus_dat_o, exp_dat_q.pop_front(), exp_sel);
        dbus_ack_i = 1'b1;
        dbus_armed = 1'b0;
      end
    end
  endtask

  // Word handed from the hold register to decode
  task automatic watch_decode();
    instr_u exp_w;
    if (dut0.if_valid && dut0.id_ready) begin
      if (dec_idx < PROG_LEN) begin
        exp_w = prog[dec_idx];
      end else begin
        exp_w = NOP_INSTR;
      end
      check_instr(dut0.if_instr, exp_w);
      dec_idx++;
    end
  endtask

  task automatic step_cycle();
    @(negedge clk_i);
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d stores still missing",
               cycle_cnt, exp_adr_q.size());
      fail_stop();
    end
    // Boot fetch due in the first cycle out of reset
    if ((cycle_cnt == 1) && !ibus_stb_o) begin
      $display("No fetch request in the first cycle after reset");
      fail_stop();
    end
    serve_ibus();
    serve_dbus();
    // Let decode see the new acks
    #1;
    watch_decode();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n_i     = 1'b0;
    boot_addr_i = BOOT_ADDR;
    ibus_dat_i  = '0;
    ibus_ack_i  = 1'b0;
    dbus_ack_i  = 1'b0;
    cycle_cnt   = 0;
    fetch_idx   = 0;
    dec_idx     = 0;
    ibus_wait   = 0;
    dbus_wait   = 0;
    ibus_armed  = 1'b0;
    dbus_armed  = 1'b0;
    rng_state   = 32'(SEED);
    for (int k = 0; k < NUM_REGS; k++) begin
      model_regs[k] = '0;
    end
    // Whole program run through the model up front
    for (int n = 0; n < PROG_LEN; n++) begin
      prog[n] = make_instr();
      model_exec(prog[n]);
    end

    repeat (8) begin
      @(negedge clk_i);
      if (ibus_cyc_o || ibus_stb_o || dbus_cyc_o || dbus_stb_o) begin
        $display("Bus request raised while reset is held");
        fail_stop();
      end
    end
    rst_n_i = 1'b1;

    // Runs until every expected store has been acked
    while ((dec_idx < PROG_LEN) || (exp_adr_q.size() != 0)) begin
      step_cycle();
    end
    // Trailing no-ops must not store
    repeat (10) begin
      step_cycle();
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: sources.f
logic/rv_core_pkg.sv
logic/register_file.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/rv_core_top.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb \
  -Mdir obj_dir \
  -f sources.f

./obj_dir/Vrv_core_tb
